/* rtl/cgra_geom_pkg.sv */
package cgra_geom_pkg;

   localparam int PE_ROWS = 4;
   localparam int PE_COLS = 4;
   localparam int DATA_W  = 8;

   typedef logic [DATA_W-1:0] lane_t;

   // one stream beat, lane 0 in the low bits
   typedef struct packed {
      logic                valid;
      lane_t [PE_COLS-1:0] lanes;
   } lane_bus_t;

endpackage

/* rtl/cgra_cfg_pkg.sv */
package cgra_cfg_pkg;

   typedef enum logic [2:0] {
      OP_PASS_A = 3'd0,
      OP_ADD    = 3'd1,
      OP_SUB    = 3'd2,
      OP_MUL    = 3'd3,
      OP_AND    = 3'd4,
      OP_OR     = 3'd5,
      OP_XOR    = 3'd6,
      OP_MAX    = 3'd7
   } alu_op_t;

   // where an operand comes from, relative to the cell's own lane
   typedef enum logic [1:0] {
      SEL_S     = 2'd0,
      SEL_SW    = 2'd1,
      SEL_SE    = 2'd2,
      SEL_CONST = 2'd3
   } opnd_sel_t;

   typedef struct packed {
      alu_op_t   op;
      opnd_sel_t sel_a;
      opnd_sel_t sel_b;
   } pe_cfg_t;

   typedef struct packed {
      logic                                door_en;
      cgra_geom_pkg::lane_t                const_a;
      cgra_geom_pkg::lane_t                const_b;
      pe_cfg_t [cgra_geom_pkg::PE_COLS-1:0] pe;
   } row_cfg_t;

   localparam int PE_CFG_W = $bits(pe_cfg_t);

   // register map, one pair of words per row
   localparam int APB_ADDR_W     = 8;
   localparam int APB_DATA_W     = 32;
   localparam int REG_ROW_STRIDE = 8;
   localparam int REG_PE_OFS     = 0;
   localparam int REG_CONST_OFS  = 4;

endpackage

/* rtl/cgra_cfg_apb.sv */
`timescale 1ns/1ps

module cgra_cfg_apb (
   input  logic                                CLK,
   input  logic                                arst_n,
   input  logic [cgra_cfg_pkg::APB_ADDR_W-1:0] paddr,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [cgra_cfg_pkg::APB_DATA_W-1:0] pwdata,
   output logic [cgra_cfg_pkg::APB_DATA_W-1:0] prdata,
   output logic                                pready,
   output logic                                pslverr,
   output cgra_cfg_pkg::row_cfg_t              cfg [cgra_geom_pkg::PE_ROWS]
);
   import cgra_geom_pkg::*;
   import cgra_cfg_pkg::*;

   localparam int ROW_SHIFT = $clog2(REG_ROW_STRIDE);
   localparam int ROW_IDX_W = $clog2(PE_ROWS);
   localparam int PE_WORD_W = PE_COLS * PE_CFG_W;
   localparam int ADDR_END  = PE_ROWS * REG_ROW_STRIDE;

   logic [ROW_IDX_W-1:0]  row_idx;
   logic [ROW_SHIFT-1:0]  word_ofs;
   logic                  addr_err;
   logic                  access;
   logic [APB_DATA_W-1:0] rd_word;

   assign row_idx  = paddr[ROW_SHIFT +: ROW_IDX_W];
   assign word_ofs = paddr[ROW_SHIFT-1:0];
   assign access   = psel & penable;

   // past the last row, or not on a word boundary
   assign addr_err = (32'(paddr) >= ADDR_END) || (paddr[1:0] != 2'b00);

   always_comb begin
      rd_word = '0;
      case (word_ofs)
         ROW_SHIFT'(REG_PE_OFS): begin
            rd_word[PE_WORD_W-1:0] = cfg[row_idx].pe;
         end
         ROW_SHIFT'(REG_CONST_OFS): begin
            rd_word[DATA_W-1:0]        = cfg[row_idx].const_a;
            rd_word[2*DATA_W-1:DATA_W] = cfg[row_idx].const_b;
            rd_word[2*DATA_W]          = cfg[row_idx].door_en;
         end
         default: begin
            rd_word = '0;
         end
      endcase
   end

   assign prdata  = (access && !pwrite && !addr_err) ? rd_word : '0;
   assign pslverr = access & addr_err;
   // no wait states
   assign pready  = 1'b1;

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         for (int r = 0; r < PE_ROWS; r++) begin
            cfg[r] <= '0;
         end
      end else if (access && pwrite && !addr_err) begin
         case (word_ofs)
            ROW_SHIFT'(REG_PE_OFS): begin
               cfg[row_idx].pe <= pwdata[PE_WORD_W-1:0];
            end
            ROW_SHIFT'(REG_CONST_OFS): begin
               cfg[row_idx].const_a <= pwdata[DATA_W-1:0];
               cfg[row_idx].const_b <= pwdata[2*DATA_W-1:DATA_W];
               cfg[row_idx].door_en <= pwdata[2*DATA_W];
            end
            default: begin
               cfg[row_idx] <= cfg[row_idx];
            end
         endcase
      end
   end

endmodule

/* rtl/pe_cell.sv */
`timescale 1ns/1ps

module pe_cell (
   input  cgra_geom_pkg::lane_t  lane_s,
   input  cgra_geom_pkg::lane_t  lane_sw,
   input  cgra_geom_pkg::lane_t  lane_se,
   input  cgra_geom_pkg::lane_t  const_a,
   input  cgra_geom_pkg::lane_t  const_b,
   input  cgra_cfg_pkg::pe_cfg_t cfg,
   output cgra_geom_pkg::lane_t  result
);
   import cgra_geom_pkg::*;
   import cgra_cfg_pkg::*;

   lane_t opnd_a;
   lane_t opnd_b;

   function automatic lane_t pick(
      input opnd_sel_t sel,
      input lane_t     s,
      input lane_t     sw,
      input lane_t     se,
      input lane_t     cst
   );
      case (sel)
         SEL_S:     pick = s;
         SEL_SW:    pick = sw;
         SEL_SE:    pick = se;
         SEL_CONST: pick = cst;
      endcase
   endfunction

   always_comb begin
      opnd_a = pick(cfg.sel_a, lane_s, lane_sw, lane_se, const_a);
      opnd_b = pick(cfg.sel_b, lane_s, lane_sw, lane_se, const_b);
      // all arithmetic wraps at 8 bits
      case (cfg.op)
         OP_PASS_A: result = opnd_a;
         OP_ADD:    result = opnd_a + opnd_b;
         OP_SUB:    result = opnd_a - opnd_b;
         OP_MUL:    result = opnd_a * opnd_b;
         OP_AND:    result = opnd_a & opnd_b;
         OP_OR:     result = opnd_a | opnd_b;
         OP_XOR:    result = opnd_a ^ opnd_b;
         OP_MAX:    result = (opnd_a > opnd_b) ? opnd_a : opnd_b;
      endcase
   end

endmodule

/* rtl/pe_row.sv */
`timescale 1ns/1ps

module pe_row (
   input  logic                     CLK,
   input  logic                     arst_n,
   input  cgra_geom_pkg::lane_bus_t below,
   input  cgra_cfg_pkg::row_cfg_t   cfg,
   output cgra_geom_pkg::lane_bus_t above
);
   import cgra_geom_pkg::*;

   // padded by a zero lane on each side for the diagonal picks
   lane_t [PE_COLS+1:0] edge_lanes;
   lane_t [PE_COLS-1:0] row_lanes;
   lane_t [PE_COLS-1:0] door_lanes;
   logic                door_vld;

   assign edge_lanes = {lane_t'(0), below.lanes, lane_t'(0)};

   for (genvar c = 0; c < PE_COLS; c++) begin : g_col
      pe_cell cell_i (
         .lane_s  (edge_lanes[c+1]),
         .lane_sw (edge_lanes[c]),
         .lane_se (edge_lanes[c+2]),
         .const_a (cfg.const_a),
         .const_b (cfg.const_b),
         .cfg     (cfg.pe[c]),
         .result  (row_lanes[c])
      );
   end

   // door register, only used when door_en is set
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         door_vld <= 1'b0;
      end else begin
         door_vld <= cfg.door_en & below.valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (cfg.door_en && below.valid) begin
         door_lanes <= row_lanes;
      end
   end

   assign above.valid = cfg.door_en ? door_vld : below.valid;
   assign above.lanes = cfg.door_en ? door_lanes : row_lanes;

endmodule

/* rtl/pe_array.sv */
`timescale 1ns/1ps

module pe_array (
   input  logic                     CLK,
   input  logic                     arst_n,
   input  cgra_geom_pkg::lane_bus_t in_bus,
   input  cgra_cfg_pkg::row_cfg_t   cfg [cgra_geom_pkg::PE_ROWS],
   output cgra_geom_pkg::lane_bus_t out_bus
);
   import cgra_geom_pkg::*;

   // link[r] enters row r from the south, link[PE_ROWS] leaves the top
   lane_bus_t           link [PE_ROWS+1];
   logic                out_vld;
   lane_t [PE_COLS-1:0] out_lanes;

   assign link[0] = in_bus;

   for (genvar r = 0; r < PE_ROWS; r++) begin : g_row
      pe_row row_i (
         .CLK    (CLK),
         .arst_n (arst_n),
         .below  (link[r]),
         .cfg    (cfg[r]),
         .above  (link[r+1])
      );
   end

   // final result register, always one cycle
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         out_vld <= 1'b0;
      end else begin
         out_vld <= link[PE_ROWS].valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (link[PE_ROWS].valid) begin
         out_lanes <= link[PE_ROWS].lanes;
      end
   end

   assign out_bus.valid = out_vld;
   assign out_bus.lanes = out_lanes;

endmodule

/* rtl/cgra_top.sv */
`timescale 1ns/1ps

module cgra_top (
   input  logic                                CLK,
   input  logic                                arst_n,
   input  logic [cgra_cfg_pkg::APB_ADDR_W-1:0] paddr,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [cgra_cfg_pkg::APB_DATA_W-1:0] pwdata,
   output logic [cgra_cfg_pkg::APB_DATA_W-1:0] prdata,
   output logic                                pready,
   output logic                                pslverr,
   input  cgra_geom_pkg::lane_bus_t            in_bus,
   output cgra_geom_pkg::lane_bus_t            out_bus
);
   import cgra_geom_pkg::*;
   import cgra_cfg_pkg::*;

   row_cfg_t cfg [PE_ROWS];

   cgra_cfg_apb cfg_apb_i (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .cfg     (cfg)
   );

   pe_array array_i (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .in_bus  (in_bus),
      .cfg     (cfg),
      .out_bus (out_bus)
   );

endmodule

/* dv/cgra_sva.sv */
`timescale 1ns/1ps

module cgra_sva (
   input logic                     CLK,
   input logic                     arst_n,
   input logic                     psel,
   input logic                     penable,
   input logic                     pready,
   input logic                     pslverr,
   input cgra_geom_pkg::lane_bus_t in_bus,
   input cgra_geom_pkg::lane_bus_t out_bus
);

   a_pready_high: assert property (@(posedge CLK) pready)
      else $error("pready went low, the APB slave has no wait states");

   a_pslverr_access: assert property (@(posedge CLK) disable iff (!arst_n)
      pslverr |-> (psel && penable))
      else $error("pslverr raised outside an APB access phase");

   a_valid_in_reset: assert property (@(posedge CLK) !arst_n |-> !out_bus.valid)
      else $error("out_bus.valid high while reset is asserted");

   // deepest path is four doors plus the final register
   a_valid_has_source: assert property (@(posedge CLK) disable iff (!arst_n)
      $rose(out_bus.valid) |-> ($past(in_bus.valid, 1) || $past(in_bus.valid, 2) ||
                                $past(in_bus.valid, 3) || $past(in_bus.valid, 4) ||
                                $past(in_bus.valid, 5)))
      else $error("out_bus.valid rose with no valid input in the last 5 cycles");

endmodule

bind cgra_top cgra_sva sva_i (
   .CLK     (CLK),
   .arst_n  (arst_n),
   .psel    (psel),
   .penable (penable),
   .pready  (pready),
   .pslverr (pslverr),
   .in_bus  (in_bus),
   .out_bus (out_bus)
);

/* dv/cgra_tb.sv */
`timescale 1ns/1ps

module cgra_tb;
   import cgra_geom_pkg::*;
   import cgra_cfg_pkg::*;

   localparam int CLK_PERIOD      = 10;
   localparam int N_TESTS         = 6;
   localparam int ITEMS_PER_TEST  = 48;
   localparam int MAX_LATENCY     = 5;
   localparam int WATCHDOG_CYCLES = N_TESTS * ITEMS_PER_TEST * (MAX_LATENCY + 20) + 2;
   localparam int ROW_CFG_W       = $bits(row_cfg_t);
   localparam int PE_WORD_W       = PE_COLS * PE_CFG_W;

   typedef lane_t [PE_COLS-1:0] lanes_t;

   typedef struct packed {
      lanes_t lanes;
      int     due;
   } exp_item_t;

   logic                  CLK;
   logic                  arst_n;
   logic [APB_ADDR_W-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_DATA_W-1:0] pwdata;
   logic [APB_DATA_W-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   lane_bus_t             in_bus;
   lane_bus_t             out_bus;

   row_cfg_t    cfg_model [PE_ROWS];
   exp_item_t   exp_q [$];
   logic [31:0] lfsr = 32'he4ef_214a;
   int          cyc = 0;
   int          err_cnt = 0;
   int          err_at_start = 0;
   int          pass_cnt = 0;
   int          fail_cnt = 0;
   string       test_name = "none";

   cgra_top dut_i (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .in_bus  (in_bus),
      .out_bus (out_bus)
   );

   initial begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   always @(posedge CLK) begin
      cyc <= cyc + 1;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired during test %s, expected output never arrived", test_name);
      $display("TESTS FAILED");
      $finish;
   end

   // galois lfsr, one step per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[62:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic lanes_t rand_lanes();
      logic [63:0] v;
      v = rand_bits(PE_COLS * DATA_W);
      return v[PE_COLS*DATA_W-1:0];
   endfunction

   function automatic lane_t operand(input opnd_sel_t sel, input lanes_t lanes, input int c,
                                     input lane_t cst);
      lane_t v;
      case (sel)
         SEL_S:   v = lanes[c];
         SEL_SW:  v = (c == 0) ? '0 : lanes[c-1];
         SEL_SE:  v = (c == PE_COLS - 1) ? '0 : lanes[c+1];
         default: v = cst;
      endcase
      return v;
   endfunction

   function automatic lane_t alu(input alu_op_t op, input lane_t a, input lane_t b);
      lane_t v;
      case (op)
         OP_ADD:  v = a + b;
         OP_SUB:  v = a - b;
         OP_MUL:  v = a * b;
         OP_AND:  v = a & b;
         OP_OR:   v = a | b;
         OP_XOR:  v = a ^ b;
         OP_MAX:  v = (a >= b) ? a : b;
         default: v = a;
      endcase
      return v;
   endfunction

   // expected top lanes, row by row from the south edge
   function automatic lanes_t model_out(input lanes_t lanes_in);
      lanes_t   cur;
      lanes_t   nxt;
      lane_t    a;
      lane_t    b;
      row_cfg_t rc;
      cur = lanes_in;
      for (int r = 0; r < PE_ROWS; r++) begin
         rc = cfg_model[r];
         for (int c = 0; c < PE_COLS; c++) begin
            a      = operand(rc.pe[c].sel_a, cur, c, rc.const_a);
            b      = operand(rc.pe[c].sel_b, cur, c, rc.const_b);
            nxt[c] = alu(rc.pe[c].op, a, b);
         end
         cur = nxt;
      end
      return cur;
   endfunction

   function automatic int door_count();
      int k;
      k = 0;
      for (int r = 0; r < PE_ROWS; r++) begin
         if (cfg_model[r].door_en) k++;
      end
      return k;
   endfunction

   function automatic logic [31:0] pe_word(input row_cfg_t rc);
      logic [31:0] w;
      w = '0;
      w[PE_WORD_W-1:0] = rc.pe;
      return w;
   endfunction

   function automatic logic [31:0] const_word(input row_cfg_t rc);
      return {15'b0, rc.door_en, rc.const_b, rc.const_a};
   endfunction

   task automatic check_word(input string what, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
      assert (act_val === exp_val) else begin
         $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp_val, act_val);
         err_cnt++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name    = name;
      err_at_start = err_cnt;
   endtask

   task automatic end_test();
      if (err_cnt == err_at_start) begin
         pass_cnt++;
         $display("test %s: passed", test_name);
      end else begin
         fail_cnt++;
         $display("test %s: failed with %0d errors", test_name, err_cnt - err_at_start);
      end
   endtask

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic err);
      @(negedge CLK);
      paddr   = addr;
      pwdata  = data;
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge CLK);
      penable = 1'b1;
      @(posedge CLK);
      err = pslverr;
      @(negedge CLK);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic err);
      @(negedge CLK);
      paddr   = addr;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge CLK);
      penable = 1'b1;
      @(posedge CLK);
      data = prdata;
      err  = pslverr;
      @(negedge CLK);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic load_row(input int r, input row_cfg_t rc);
      logic err;
      apb_write(8'(r * REG_ROW_STRIDE + REG_PE_OFS), pe_word(rc), err);
      check_word("pe word write pslverr", 32'h0, 32'(err));
      apb_write(8'(r * REG_ROW_STRIDE + REG_CONST_OFS), const_word(rc), err);
      check_word("const word write pslverr", 32'h0, 32'(err));
      cfg_model[r] = rc;
   endtask

   task automatic verify_regs();
      logic [31:0] rdata;
      logic        err;
      for (int r = 0; r < PE_ROWS; r++) begin
         apb_read(8'(r * REG_ROW_STRIDE + REG_PE_OFS), rdata, err);
         check_word("pe word readback", pe_word(cfg_model[r]), rdata);
         check_word("readback pslverr", 32'h0, 32'(err));
         apb_read(8'(r * REG_ROW_STRIDE + REG_CONST_OFS), rdata, err);
         check_word("const word readback", const_word(cfg_model[r]), rdata);
         check_word("readback pslverr", 32'h0, 32'(err));
      end
   endtask

   task automatic send(input logic vld, input lanes_t lanes);
      exp_item_t item;
      @(negedge CLK);
      in_bus.valid = vld;
      in_bus.lanes = lanes;
      if (vld) begin
         item.lanes = model_out(lanes);
         item.due   = cyc + 1 + door_count();
         exp_q.push_back(item);
      end
   endtask

   task automatic drain();
      @(negedge CLK);
      in_bus.valid = 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge CLK);
      end
      repeat (MAX_LATENCY) @(negedge CLK);
   endtask

   // out_bus is registered, so it is steady at the falling edge
   task automatic watch_output();
      exp_item_t item;
      forever begin
         @(negedge CLK);
         if (arst_n && out_bus.valid) begin
            if (exp_q.size() == 0) begin
               $display("%s: valid output %h arrived with no item expected",
                        test_name, out_bus.lanes);
               err_cnt++;
            end else begin
               item = exp_q.pop_front();
               check_word("arrival cycle", item.due, cyc);
               check_word("lanes", item.lanes, out_bus.lanes);
            end
         end
      end
   endtask

   task automatic test_reset_default();
      begin_test("reset_default");
      verify_regs();
      for (int i = 0; i < 8; i++) send(1'b1, rand_lanes());
      drain();
      end_test();
   endtask

   task automatic test_reg_file();
      logic [63:0] v;
      logic [31:0] rdata;
      logic        err;
      begin_test("apb_reg_file");
      for (int r = 0; r < PE_ROWS; r++) begin
         v = rand_bits(32);
         apb_write(8'(r * REG_ROW_STRIDE + REG_PE_OFS), v[31:0], err);
         check_word("pe word write pslverr", 32'h0, 32'(err));
         cfg_model[r].pe = v[PE_WORD_W-1:0];
         v = rand_bits(32);
         apb_write(8'(r * REG_ROW_STRIDE + REG_CONST_OFS), v[31:0], err);
         check_word("const word write pslverr", 32'h0, 32'(err));
         cfg_model[r].const_a = v[7:0];
         cfg_model[r].const_b = v[15:8];
         cfg_model[r].door_en = v[16];
      end
      verify_regs();
      apb_write(8'(PE_ROWS * REG_ROW_STRIDE), 32'hffff_ffff, err);
      check_word("pslverr above last row", 32'h1, 32'(err));
      apb_write(8'(REG_CONST_OFS + 2), 32'hffff_ffff, err);
      check_word("pslverr misaligned write", 32'h1, 32'(err));
      // aliases onto row 0's const word if the range check is missing
      apb_read(8'(PE_ROWS * REG_ROW_STRIDE + REG_CONST_OFS), rdata, err);
      check_word("pslverr read above last row", 32'h1, 32'(err));
      check_word("error read data", 32'h0, rdata);
      apb_read(8'(REG_PE_OFS + 1), rdata, err);
      check_word("pslverr misaligned read", 32'h1, 32'(err));
      verify_regs();
      end_test();
   endtask

   task automatic test_alu_ops();
      row_cfg_t    rc;
      logic [63:0] v;
      begin_test("alu_ops");
      for (int r = 1; r < PE_ROWS; r++) load_row(r, '0);
      for (int op = 0; op < 8; op++) begin
         rc         = '0;
         v          = rand_bits(16);
         rc.const_a = v[7:0];
         rc.const_b = v[15:8];
         for (int c = 0; c < PE_COLS; c++) begin
            rc.pe[c].op    = alu_op_t'(3'(op));
            // constant swaps sides between opcodes
            rc.pe[c].sel_a = op[0] ? SEL_S : SEL_CONST;
            rc.pe[c].sel_b = op[0] ? SEL_CONST : SEL_S;
         end
         load_row(0, rc);
         for (int i = 0; i < 4; i++) send(1'b1, rand_lanes());
         drain();
      end
      end_test();
   endtask

   task automatic test_diagonal();
      row_cfg_t rc;
      begin_test("diagonal_links");
      rc = '0;
      for (int c = 0; c < PE_COLS; c++) rc.pe[c].sel_a = SEL_SW;
      load_row(0, rc);
      load_row(1, rc);
      for (int c = 0; c < PE_COLS; c++) rc.pe[c].sel_a = SEL_SE;
      load_row(2, rc);
      for (int c = 0; c < PE_COLS; c++) begin
         rc.pe[c].op    = OP_XOR;
         rc.pe[c].sel_b = SEL_SW;
      end
      load_row(3, rc);
      for (int i = 0; i < 8; i++) send(1'b1, rand_lanes());
      drain();
      end_test();
   endtask

   task automatic test_doors();
      row_cfg_t rc;
      begin_test("door_registers");
      for (int k = 0; k <= PE_ROWS; k++) begin
         for (int r = 0; r < PE_ROWS; r++) begin
            rc         = '0;
            rc.door_en = (r < k);
            rc.const_b = 8'(r + 1);
            for (int c = 0; c < PE_COLS; c++) begin
               rc.pe[c].op    = OP_ADD;
               rc.pe[c].sel_b = SEL_CONST;
            end
            load_row(r, rc);
         end
         for (int i = 0; i < 6; i++) send(1'b1, rand_lanes());
         drain();
      end
      end_test();
   endtask

   task automatic test_random();
      logic [63:0] v;
      begin_test("random_config");
      for (int round = 0; round < 4; round++) begin
         for (int r = 0; r < PE_ROWS; r++) begin
            v = rand_bits(ROW_CFG_W);
            load_row(r, row_cfg_t'(v[ROW_CFG_W-1:0]));
         end
         // roughly three beats in four carry data
         for (int i = 0; i < 10; i++) begin
            v = rand_bits(2);
            send(v[1:0] != 2'b00, rand_lanes());
         end
         drain();
      end
      end_test();
   endtask

   initial begin
      arst_n  = 1'b0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      in_bus  = '0;
      for (int r = 0; r < PE_ROWS; r++) cfg_model[r] = '0;
      repeat (2) @(posedge CLK);
      @(negedge CLK);
      arst_n = 1'b1;
      fork
         watch_output();
      join_none
      test_reset_default();
      test_reg_file();
      test_alu_ops();
      test_diagonal();
      test_doors();
      test_random();
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               N_TESTS, pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* src.f */
rtl/cgra_geom_pkg.sv
rtl/cgra_cfg_pkg.sv
rtl/cgra_cfg_apb.sv
rtl/pe_cell.sv
rtl/pe_row.sv
rtl/pe_array.sv
rtl/cgra_top.sv
dv/cgra_sva.sv
dv/cgra_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the CGRA testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
      --top-module cgra_tb -Mdir obj_dir -f src.f; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vcgra_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^TESTS PASSED$"; then
   exit 0
else
   exit 1
fi
